// File: tb.f
+incdir+tb
src/dz_pkg.sv
src/scan_if.sv
src/digit_if.sv
src/countdown_sequencer.sv
src/row_scanner.sv
src/matrix_driver.sv
src/countdown_display.sv
tb/tb_countdown_display.sv

// File: run.sh
#!/bin/sh
# build and run the countdown display testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f \
    --top-module tb_countdown_display \
    -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: tb/glyph_ref.svh
`ifndef GLYPH_REF_SVH
`define GLYPH_REF_SVH

// colour bands as the testbench tracks them
localparam int BAND_RED    = 0;
localparam int BAND_YELLOW = 1;   // both buses lit
localparam int BAND_GREEN  = 2;

// whole bitmap of one digit, top row in the upper byte, msb is column 7
function automatic logic [63:0] glyph_word(int d);
    logic [63:0] w;
    case (d)
        7:       w = 64'h007E_060C_1830_3030;
        6:       w = 64'h003C_607C_6666_663C;
        5:       w = 64'h007E_607C_0606_663C;
        4:       w = 64'h000C_1C2C_4C7E_0C0C;
        3:       w = 64'h003C_6606_1C06_663C;
        2:       w = 64'h003C_6606_0C30_607E;
        1:       w = 64'h0018_1838_1818_187E;
        default: w = 64'h003C_4242_4242_423C;
    endcase
    return w;
endfunction

// one row of the bitmap
function automatic logic [7:0] glyph_bits(int d, int r);
    logic [63:0] w;
    logic [63:0] s;
    w = glyph_word(d);
    s = w >> (8 * (7 - r));
    return s[7:0];
endfunction

// 7..4 red, 3 and 2 yellow, 1 and 0 green
function automatic int color_band(int d);
    int band;
    if (d >= 4)
        band = BAND_RED;
    else if (d >= 2)
        band = BAND_YELLOW;
    else
        band = BAND_GREEN;
    return band;
endfunction

`endif

// File: tb/tb_countdown_display.sv
module tb_countdown_display;

    localparam int CLK_HALF     = 50;
    localparam int RESET_CYCLES = 16;
    localparam int FULL_RUN     = 9 * dz_pkg::STEP_CYCLES + 24;  // reaches 0 and holds
    localparam int FULL_GAP     = 6;
    localparam int NUM_RESTARTS = 8;

    logic       clk;
    logic       rst;
    logic       start;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;

    int   hi_cnt       = 0;     // consecutive edges that saw start high
    int   exp_n        = 0;     // position of the shown frame within the run
    logic exp_lit      = 1'b0;
    int   value_errs   = 0;
    int   prop_errs    = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    int   test_no      = 0;
    int   limit_cycles = 0;
    int   gaps [NUM_RESTARTS];
    int   runs [NUM_RESTARTS];

    `include "glyph_ref.svh"

    countdown_display UUT (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

    always #CLK_HALF clk = ~clk;

    // output after edge k of a run shows scan step k-1, the first high edge is still blank
    always @(posedge clk)
    begin
        if (rst)
        begin
            hi_cnt  = 0;
            exp_lit = 1'b0;
        end
        else
        begin
            exp_n   = hi_cnt;
            exp_lit = (hi_cnt >= 1);
            hi_cnt  = start ? hi_cnt + 1 : 0;
        end
    end

    task automatic report_value(string name, logic [7:0] expected, logic [7:0] actual);
        value_errs++;
        $display("[ERROR] t=%0t %s expected %02h got %02h", $time, name, expected, actual);
    endtask

    always @(negedge clk)
    begin
        int         step;
        int         d;
        int         r;
        int         band;
        logic [7:0] pat;
        logic [7:0] e_row;
        logic [7:0] e_r;
        logic [7:0] e_g;
        e_row = 8'hFF;
        e_r   = 8'h00;
        e_g   = 8'h00;
        if (exp_lit)
        begin
            step  = (exp_n - 1) / dz_pkg::STEP_CYCLES;
            d     = 7 - ((step > 7) ? 7 : step);   // holds at 0
            r     = ((exp_n - 1) / dz_pkg::SCAN_DIV) % dz_pkg::ROWS;
            pat   = glyph_bits(d, r);
            band  = color_band(d);
            e_row = ~(8'h01 << r);
            e_r   = (band == BAND_GREEN) ? 8'h00 : pat;
            e_g   = (band == BAND_RED) ? 8'h00 : pat;
        end
        assert (row === e_row) else report_value("row", e_row, row);
        assert (colr === e_r) else report_value("colr", e_r, colr);
        assert (colg === e_g) else report_value("colg", e_g, colg);
    end

    // never more than one row driven
    assert property (@(posedge clk) $countones(~row) <= 1)
        else
        begin
            prop_errs++;
            $display("[ERROR] t=%0t row expected at most one low bit got %02h", $time, row);
        end

    // a lit row is only ever followed by the next row
    assert property (@(posedge clk) disable iff (rst)
        (row != $past(row) && row != 8'hFF && $past(row) != 8'hFF)
        |-> (row == {$past(row[6:0]), $past(row[7])}))
        else
        begin
            prop_errs++;
            $display("[ERROR] t=%0t row did not step to the next row, got %02h", $time, row);
        end

    assert property (@(posedge clk) (row == 8'hFF) |-> (colr == 8'h00 && colg == 8'h00))
        else
        begin
            prop_errs++;
            $display("[ERROR] t=%0t columns lit while no row is driven", $time);
        end

    function automatic int total_errors();
        return value_errs + prop_errs;
    endfunction

    // start high for run_len edges, then low for gap_len edges (last one in finish_test)
    task automatic run_segment(int run_len, int gap_len);
        #5 start = 1'b1;
        repeat (run_len) @(posedge clk);
        #5 start = 1'b0;
        repeat (gap_len - 1) @(posedge clk);
    endtask

    task automatic finish_test(string name, int base);
        int errs;
        @(negedge clk);
        #1;
        errs = total_errors() - base;
        test_no++;
        if (errs == 0)
        begin
            tests_passed++;
            $display("test %0d %s: passed", test_no, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", test_no, name, errs);
        end
        @(posedge clk);
    endtask

    initial
    begin
        int total;
        int base;
        clk   = 1'b0;
        rst   = 1'b1;
        start = 1'b0;
        void'($urandom(3));

        total = RESET_CYCLES + 8 + FULL_RUN + FULL_GAP;
        for (int i = 0; i < NUM_RESTARTS; i++)
        begin
            gaps[i] = int'($urandom_range(40, 1));
            runs[i] = int'($urandom_range(9 * dz_pkg::STEP_CYCLES, 1));
            total += gaps[i] + runs[i] + 1;
        end
        limit_cycles = total + 2 * dz_pkg::STEP_CYCLES;

        base = total_errors();
        repeat (RESET_CYCLES) @(posedge clk);
        #5 rst = 1'b0;
        repeat (4) @(posedge clk);   // idle with start low
        finish_test("reset state", base);

        base = total_errors();
        run_segment(FULL_RUN, FULL_GAP);
        finish_test("full countdown and hold", base);

        for (int i = 0; i < NUM_RESTARTS; i++)
        begin
            base = total_errors();
            run_segment(runs[i], gaps[i]);
            finish_test($sformatf("restart run %0d gap %0d", runs[i], gaps[i]), base);
        end

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, total_errors());
        if (total_errors() == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("simulation timed out after %0d cycles before the tests finished",
                 limit_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: src/countdown_display.sv
module countdown_display (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    output logic [dz_pkg::ROWS-1:0] row,
    output logic [dz_pkg::COLS-1:0] colr,
    output logic [dz_pkg::COLS-1:0] colg
);

    digit_if dig ();
    scan_if  scan ();

    // sequencer and scanner both start on the same edge
    countdown_sequencer u_seq (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .dig   (dig.seq)
    );

    row_scanner u_scan (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .scan  (scan.scan)
    );

    matrix_driver u_drv (
        .clk   (clk),
        .rst   (rst),
        .dig   (dig.drv),
        .scan  (scan.drv),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

endmodule

// File: src/matrix_driver.sv
module matrix_driver (
    input  logic                    clk,
    input  logic                    rst,
    digit_if.drv                    dig,
    scan_if.drv                     scan,
    output logic [dz_pkg::ROWS-1:0] row,
    output logic [dz_pkg::COLS-1:0] colr,
    output logic [dz_pkg::COLS-1:0] colg
);

    dz_pkg::digit_t          frame_digit;
    dz_pkg::color_e          frame_color;
    dz_pkg::digit_t          cur_digit;
    dz_pkg::color_e          cur_color;
    logic                    active;
    logic                    red_on;
    logic                    green_on;
    logic [dz_pkg::COLS-1:0] pattern;
    logic [dz_pkg::ROWS-1:0] row_sel;

    // bitmaps for 0..7, row 0 is the blank top line
    function automatic logic [dz_pkg::COLS-1:0] glyph_row(dz_pkg::digit_t d,
                                                          dz_pkg::row_idx_t r);
        logic [dz_pkg::COLS-1:0] pat;
        pat = '0;
        case (d)
            3'd7:
                case (r)
                    3'd1:             pat = 8'b0111_1110;
                    3'd2:             pat = 8'b0000_0110;
                    3'd3:             pat = 8'b0000_1100;
                    3'd4:             pat = 8'b0001_1000;
                    3'd5, 3'd6, 3'd7: pat = 8'b0011_0000;
                    default:          pat = '0;
                endcase
            3'd6:
                case (r)
                    3'd1, 3'd7:       pat = 8'b0011_1100;
                    3'd2:             pat = 8'b0110_0000;
                    3'd3:             pat = 8'b0111_1100;
                    3'd4, 3'd5, 3'd6: pat = 8'b0110_0110;
                    default:          pat = '0;
                endcase
            3'd5:
                case (r)
                    3'd1:       pat = 8'b0111_1110;
                    3'd2:       pat = 8'b0110_0000;
                    3'd3:       pat = 8'b0111_1100;
                    3'd4, 3'd5: pat = 8'b0000_0110;
                    3'd6:       pat = 8'b0110_0110;
                    3'd7:       pat = 8'b0011_1100;
                    default:    pat = '0;
                endcase
            3'd4:
                case (r)
                    3'd1, 3'd6, 3'd7: pat = 8'b0000_1100;
                    3'd2:             pat = 8'b0001_1100;
                    3'd3:             pat = 8'b0010_1100;
                    3'd4:             pat = 8'b0100_1100;
                    3'd5:             pat = 8'b0111_1110;
                    default:          pat = '0;
                endcase
            3'd3:
                case (r)
                    3'd1, 3'd7: pat = 8'b0011_1100;
                    3'd2, 3'd6: pat = 8'b0110_0110;
                    3'd3, 3'd5: pat = 8'b0000_0110;
                    3'd4:       pat = 8'b0001_1100;
                    default:    pat = '0;
                endcase
            3'd2:
                case (r)
                    3'd1:    pat = 8'b0011_1100;
                    3'd2:    pat = 8'b0110_0110;
                    3'd3:    pat = 8'b0000_0110;
                    3'd4:    pat = 8'b0000_1100;
                    3'd5:    pat = 8'b0011_0000;
                    3'd6:    pat = 8'b0110_0000;
                    3'd7:    pat = 8'b0111_1110;
                    default: pat = '0;
                endcase
            3'd1:
                case (r)
                    3'd1, 3'd2, 3'd4, 3'd5, 3'd6: pat = 8'b0001_1000;
                    3'd3:                         pat = 8'b0011_1000;
                    3'd7:                         pat = 8'b0111_1110;
                    default:                      pat = '0;
                endcase
            default:
                case (r)
                    3'd1, 3'd7:                   pat = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5, 3'd6: pat = 8'b0100_0010;
                    default:                      pat = '0;
                endcase
        endcase
        return pat;
    endfunction

    // digit and colour are frozen per frame so a glyph never tears mid-scan
    always_ff @(posedge clk)
    begin
        if (scan.frame_start)
        begin
            frame_digit <= dig.digit;
            frame_color <= dig.color;
        end
    end

    assign cur_digit = scan.frame_start ? dig.digit : frame_digit;
    assign cur_color = scan.frame_start ? dig.color : frame_color;

    assign active   = dig.run && scan.scanning;
    assign pattern  = glyph_row(cur_digit, scan.row_idx);
    assign red_on   = (cur_color != dz_pkg::COLOR_GREEN);
    assign green_on = (cur_color != dz_pkg::COLOR_RED);

    always_comb
    begin
        for (int i = 0; i < dz_pkg::ROWS; i++)
            row_sel[i] = (scan.row_idx != dz_pkg::row_idx_t'(i));  // active low
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;
            colr <= '0;
            colg <= '0;
        end
        else if (!active)
        begin
            row  <= '1;
            colr <= '0;
            colg <= '0;
        end
        else if (scan.row_start)   // drive only changes at slot boundaries
        begin
            row  <= row_sel;
            colr <= red_on ? pattern : '0;
            colg <= green_on ? pattern : '0;
        end
    end

endmodule

// File: src/row_scanner.sv
module row_scanner (
    input  logic clk,
    input  logic rst,
    input  logic start,
    scan_if.scan scan
);

    dz_pkg::scan_cnt_t presc;     // clocks within the current slot
    logic              slot_end;
    logic              last_row;

    assign slot_end = (presc == dz_pkg::scan_cnt_t'(dz_pkg::SCAN_DIV - 1));
    assign last_row = (scan.row_idx == dz_pkg::row_idx_t'(dz_pkg::ROWS - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan.scanning    <= 1'b0;
            scan.row_idx     <= '0;
            scan.row_start   <= 1'b0;
            scan.frame_start <= 1'b0;
            presc            <= '0;
        end
        else if (!start)
        begin
            scan.scanning    <= 1'b0;
            scan.row_idx     <= '0;
            scan.row_start   <= 1'b0;
            scan.frame_start <= 1'b0;
            presc            <= '0;
        end
        else if (!scan.scanning)
        begin
            // first slot of the first frame
            scan.scanning    <= 1'b1;
            scan.row_idx     <= '0;
            scan.row_start   <= 1'b1;
            scan.frame_start <= 1'b1;
            presc            <= '0;
        end
        else if (slot_end)
        begin
            presc            <= '0;
            scan.row_idx     <= last_row ? '0 : scan.row_idx + 1'b1;
            scan.row_start   <= 1'b1;
            scan.frame_start <= last_row;  // wrapping back to row 0
        end
        else
        begin
            presc            <= presc + 1'b1;
            scan.row_start   <= 1'b0;
            scan.frame_start <= 1'b0;
        end
    end

endmodule

// File: src/countdown_sequencer.sv
module countdown_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    digit_if.seq dig
);

    dz_pkg::step_cnt_t step_cnt;
    dz_pkg::digit_t    next_digit;
    logic              step_done;

    assign step_done = (step_cnt == dz_pkg::step_cnt_t'(dz_pkg::STEP_CYCLES - 1));

    // saturate at 0
    assign next_digit = (dig.digit == '0) ? dig.digit : dig.digit - 1'b1;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dig.run   <= 1'b0;
            dig.digit <= dz_pkg::FIRST_DIGIT;
            dig.color <= dz_pkg::color_of(dz_pkg::FIRST_DIGIT);
            dig.last  <= 1'b0;
            step_cnt  <= '0;
        end
        else if (!start)
        begin
            // idle, armed for the next start
            dig.run   <= 1'b0;
            dig.digit <= dz_pkg::FIRST_DIGIT;
            dig.color <= dz_pkg::color_of(dz_pkg::FIRST_DIGIT);
            dig.last  <= 1'b0;
            step_cnt  <= '0;
        end
        else
        begin
            dig.run <= 1'b1;
            if (dig.run)
            begin
                step_cnt <= step_done ? '0 : step_cnt + 1'b1;
                if (step_done)
                begin
                    // colour follows the new digit on the same edge
                    dig.digit <= next_digit;
                    dig.color <= dz_pkg::color_of(next_digit);
                    dig.last  <= (next_digit == '0);
                end
            end
        end
    end

endmodule

// File: src/digit_if.sv
// digit and colour band from the sequencer to the driver
interface digit_if;

    logic           run;
    dz_pkg::digit_t digit;
    dz_pkg::color_e color;
    logic           last;   // at 0 and holding

    modport seq
    (
        output run,
        output digit,
        output color,
        output last
    );

    modport drv
    (
        input run,
        input digit,
        input color,
        input last
    );

endinterface

// File: src/scan_if.sv
// row timing from the scanner to the driver
interface scan_if;

    logic             scanning;     // a row slot is valid
    dz_pkg::row_idx_t row_idx;
    logic             row_start;    // first cycle of a slot
    logic             frame_start;  // first cycle of row 0

    modport scan
    (
        output scanning,
        output row_idx,
        output row_start,
        output frame_start
    );

    modport drv
    (
        input scanning,
        input row_idx,
        input row_start,
        input frame_start
    );

endinterface

// File: src/dz_pkg.sv
package dz_pkg;

    // matrix geometry
    localparam int ROWS = 8;
    localparam int COLS = 8;

    localparam int SCAN_DIV        = 4;   // clocks per row slot
    localparam int FRAMES_PER_STEP = 2;   // whole frames per digit

    // one digit stays up for this many clocks
    localparam int STEP_CYCLES = SCAN_DIV * ROWS * FRAMES_PER_STEP;

    typedef logic [2:0] digit_t;
    typedef logic [2:0] row_idx_t;

    // counter types sized from the timing constants
    typedef logic [$clog2(SCAN_DIV)-1:0]    scan_cnt_t;
    typedef logic [$clog2(STEP_CYCLES)-1:0] step_cnt_t;

    localparam digit_t FIRST_DIGIT = 3'd7;

    typedef enum logic [1:0]
    {
        COLOR_RED,
        COLOR_YELLOW,   // red and green lit together
        COLOR_GREEN
    } color_e;

    // 7..4 red, 3..2 yellow, 1..0 green
    function automatic color_e color_of(digit_t d);
        color_e c;
        if (d >= 3'd4)
            c = COLOR_RED;
        else if (d >= 3'd2)
            c = COLOR_YELLOW;
        else
            c = COLOR_GREEN;
        return c;
    endfunction

endpackage
